//--- design/fb_pkg.sv
// Frame geometry, command field positions, pixel and stream typedefs, opcode and state enums
package fb_pkg;

    // Frame geometry, 16 x 8 pixels stored row by row
    localparam int FB_WIDTH        = 16;
    localparam int FB_HEIGHT       = 8;
    localparam int FB_WORDS        = FB_WIDTH * FB_HEIGHT;
    localparam int PIXELS_PER_BEAT = 2;
    localparam int BEATS_PER_FRAME = FB_WORDS / PIXELS_PER_BEAT;
    localparam int SUB_PIXEL_WIDTH = 6;

    // Command word fields
    // Opcode sits in the top nibble, coordinates below it
    localparam int CMD_OP_LSB         = 28;
    localparam int CMD_X_LSB          = 24;
    localparam int CMD_Y_LSB          = 21;
    localparam int CMD_SCISSOR_EN_BIT = 0;

    typedef logic [$clog2(FB_WIDTH)-1:0]  screen_x_t;
    typedef logic [$clog2(FB_HEIGHT)-1:0] screen_y_t;

    // Row in the upper bits, column in the lower bits
    typedef logic [$clog2(FB_WORDS)-1:0]  fb_addr_t;

    typedef logic [SUB_PIXEL_WIDTH-1:0]   sub_pixel_t;

    // Red on top, then green, then blue
    typedef logic [3*SUB_PIXEL_WIDTH-1:0] pixel_t;

    // One write enable per channel, red in the MSB
    typedef logic [2:0]                   channel_mask_t;

    typedef logic [15:0]                  rgb565_t;
    typedef logic [31:0]                  cmd_word_t;
    typedef logic [31:0]                  stream_word_t;

    // Opcode zero and 8..15 are consumed without effect
    typedef enum logic [3:0]
    {
        OP_CLEAR_COLOR   = 4'h1,  // colour in bits 17..0
        OP_SCISSOR_START = 4'h2,  // x, y and enable bit
        OP_SCISSOR_END   = 4'h3,  // inclusive x, y
        OP_MASK          = 4'h4,  // mask in bits 2..0
        OP_PIXEL         = 4'h5,  // x, y and colour
        OP_MEMSET        = 4'h6,
        OP_COMMIT        = 4'h7
    } cmd_op_t;

    // Requests from the decoder to the colour buffer
    typedef enum logic [1:0]
    {
        REQ_WRITE,
        REQ_MEMSET,
        REQ_COMMIT
    } buf_req_t;

    // Colour buffer sequencer
    typedef enum logic [1:0]
    {
        ST_IDLE,
        ST_MEMSET,
        ST_COMMIT
    } buf_state_t;

endpackage

//--- design/cmd_decoder.sv
`timescale 1ns/1ps
// Command decoder with configuration registers and a one-entry buffer request register
module cmd_decoder
(
    input  logic                  aclk,
    input  logic                  arst_n,

    // Command stream
    input  logic                  s_cmd_tvalid,
    output logic                  s_cmd_tready,
    input  fb_pkg::cmd_word_t     s_cmd_tdata,

    // Buffer request
    output logic                  req_valid,
    input  logic                  req_ready,
    output fb_pkg::buf_req_t      req_kind,
    output fb_pkg::screen_x_t     req_x,
    output fb_pkg::screen_y_t     req_y,
    output fb_pkg::pixel_t        req_color,

    // Configuration
    output logic                  scissor_enable,
    output fb_pkg::screen_x_t     scissor_start_x,
    output fb_pkg::screen_y_t     scissor_start_y,
    output fb_pkg::screen_x_t     scissor_end_x,
    output fb_pkg::screen_y_t     scissor_end_y,
    output fb_pkg::channel_mask_t write_mask
);
    import fb_pkg::*;

    cmd_op_t   cmd_op;
    screen_x_t cmd_x;
    screen_y_t cmd_y;
    pixel_t    cmd_color;
    pixel_t    clear_color;
    logic      accept;

    assign cmd_op    = cmd_op_t'(s_cmd_tdata[CMD_OP_LSB +: 4]);
    assign cmd_x     = s_cmd_tdata[CMD_X_LSB +: $bits(screen_x_t)];
    assign cmd_y     = s_cmd_tdata[CMD_Y_LSB +: $bits(screen_y_t)];
    assign cmd_color = s_cmd_tdata[$bits(pixel_t)-1:0];

    // Stall only while a request waits and the buffer cannot take it
    assign s_cmd_tready = !req_valid || req_ready;
    assign accept       = s_cmd_tvalid && s_cmd_tready;

    // Configuration registers
    always_ff @(posedge aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            clear_color     <= '0;
            scissor_enable  <= 1'b0;
            scissor_start_x <= '0;
            scissor_start_y <= '0;
            scissor_end_x   <= screen_x_t'(FB_WIDTH - 1);
            scissor_end_y   <= screen_y_t'(FB_HEIGHT - 1);
            write_mask      <= '1;
        end
        else if (accept)
        begin
            case (cmd_op)
                OP_CLEAR_COLOR:
                    clear_color <= cmd_color;
                OP_SCISSOR_START:
                begin
                    scissor_start_x <= cmd_x;
                    scissor_start_y <= cmd_y;
                    scissor_enable  <= s_cmd_tdata[CMD_SCISSOR_EN_BIT];
                end
                OP_SCISSOR_END:
                begin
                    scissor_end_x <= cmd_x;
                    scissor_end_y <= cmd_y;
                end
                OP_MASK:
                    write_mask <= s_cmd_tdata[$bits(channel_mask_t)-1:0];
                default:
                    ;
            endcase
        end
    end

    // Request register
    always_ff @(posedge aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            req_valid <= 1'b0;
            req_kind  <= REQ_WRITE;
        end
        else if (accept && (cmd_op == OP_PIXEL || cmd_op == OP_MEMSET || cmd_op == OP_COMMIT))
        begin
            req_valid <= 1'b1;
            case (cmd_op)
                OP_PIXEL:  req_kind <= REQ_WRITE;
                OP_MEMSET: req_kind <= REQ_MEMSET;
                default:   req_kind <= REQ_COMMIT;
            endcase
        end
        else if (req_ready)
        begin
            req_valid <= 1'b0;
        end
    end

    // Request payload
    always_ff @(posedge aclk)
    begin
        if (accept)
        begin
            req_x     <= cmd_x;
            req_y     <= cmd_y;
            // Memset carries the clear colour
            req_color <= (cmd_op == OP_PIXEL) ? cmd_color : clear_color;
        end
    end

endmodule

//--- design/color_buffer.sv
`timescale 1ns/1ps
// Colour buffer with channel-masked pixel memory, scissor test, memset and commit sequencers
module color_buffer
(
    input  logic                                          aclk,
    input  logic                                          arst_n,

    // Buffer request
    input  logic                                          req_valid,
    output logic                                          req_ready,
    input  fb_pkg::buf_req_t                              req_kind,
    input  fb_pkg::screen_x_t                             req_x,
    input  fb_pkg::screen_y_t                             req_y,
    input  fb_pkg::pixel_t                                req_color,

    // Configuration
    input  logic                                          scissor_enable,
    input  fb_pkg::screen_x_t                             scissor_start_x,
    input  fb_pkg::screen_y_t                             scissor_start_y,
    input  fb_pkg::screen_x_t                             scissor_end_x,
    input  fb_pkg::screen_y_t                             scissor_end_y,
    input  fb_pkg::channel_mask_t                         write_mask,

    // Pixel pairs to the stream converter
    output logic                                          pair_valid,
    input  logic                                          pair_ready,
    output fb_pkg::pixel_t [fb_pkg::PIXELS_PER_BEAT-1:0]  pair_data,
    output logic                                          pair_last
);
    import fb_pkg::*;

    buf_state_t state;
    fb_addr_t   seq_addr;
    fb_addr_t   wr_addr;
    screen_x_t  wr_x;
    screen_y_t  wr_y;
    logic       wr_en;
    logic       in_scissor;
    logic       rd_en;
    logic       last_read;
    sub_pixel_t rd_even [$bits(channel_mask_t)];
    sub_pixel_t rd_odd  [$bits(channel_mask_t)];

    // Read when the output register is empty or drains this cycle
    assign rd_en     = (state == ST_COMMIT) && (!pair_valid || pair_ready);
    assign last_read = (seq_addr == fb_addr_t'(FB_WORDS - PIXELS_PER_BEAT));

    // Memset and commit hold their request until the sequence ends
    always_comb
    begin
        case (state)
            ST_IDLE:   req_ready = (req_kind == REQ_WRITE);
            ST_MEMSET: req_ready = (seq_addr == fb_addr_t'(FB_WORDS - 1));
            default:   req_ready = rd_en && last_read;
        endcase
    end

    // Write port shared by pixel writes and the memset walk
    assign wr_addr      = (state == ST_MEMSET) ? seq_addr : {req_y, req_x};
    assign {wr_y, wr_x} = wr_addr;

    assign in_scissor = !scissor_enable
                     || ((wr_x >= scissor_start_x) && (wr_x <= scissor_end_x)
                      && (wr_y >= scissor_start_y) && (wr_y <= scissor_end_y));

    assign wr_en = in_scissor
                && ((state == ST_MEMSET)
                 || ((state == ST_IDLE) && req_valid && (req_kind == REQ_WRITE)));

    // Sequencer and output register control
    always_ff @(posedge aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state      <= ST_IDLE;
            seq_addr   <= '0;
            pair_valid <= 1'b0;
            pair_last  <= 1'b0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    seq_addr <= '0;
                    if (req_valid && (req_kind == REQ_MEMSET))
                        state <= ST_MEMSET;
                    else if (req_valid && (req_kind == REQ_COMMIT))
                        state <= ST_COMMIT;
                end
                ST_MEMSET:
                begin
                    seq_addr <= seq_addr + 1'b1;
                    if (req_ready)
                        state <= ST_IDLE;
                end
                ST_COMMIT:
                begin
                    if (rd_en)
                    begin
                        seq_addr <= seq_addr + fb_addr_t'(PIXELS_PER_BEAT);
                        if (last_read)
                            state <= ST_IDLE;
                    end
                end
                default:
                    state <= ST_IDLE;
            endcase

            if (rd_en)
            begin
                pair_valid <= 1'b1;
                pair_last  <= last_read;
            end
            else if (pair_ready)
            begin
                pair_valid <= 1'b0;
            end
        end
    end

    // One array per channel so the mask gates each write enable
    for (genvar c = 0; c < $bits(channel_mask_t); c++)
    begin : g_channel
        sub_pixel_t mem [FB_WORDS];

        always_ff @(posedge aclk)
        begin
            if (wr_en && write_mask[c])
                mem[wr_addr] <= req_color[c*SUB_PIXEL_WIDTH +: SUB_PIXEL_WIDTH];
            if (rd_en)
            begin
                rd_even[c] <= mem[seq_addr];
                rd_odd[c]  <= mem[seq_addr | fb_addr_t'(1)];
            end
        end
    end

    // Even column in the low half
    assign pair_data = {rd_odd[2], rd_odd[1], rd_odd[0], rd_even[2], rd_even[1], rd_even[0]};

endmodule

//--- design/fb_stream_out.sv
`timescale 1ns/1ps
// RGB565 conversion of pixel pairs and two-entry output queue for the framebuffer stream
module fb_stream_out
(
    input  logic                                          aclk,
    input  logic                                          arst_n,

    // Pixel pairs from the colour buffer
    input  logic                                          pair_valid,
    output logic                                          pair_ready,
    input  fb_pkg::pixel_t [fb_pkg::PIXELS_PER_BEAT-1:0]  pair_data,
    input  logic                                          pair_last,

    // Framebuffer stream
    output logic                                          m_fb_tvalid,
    input  logic                                          m_fb_tready,
    output fb_pkg::stream_word_t                          m_fb_tdata,
    output logic                                          m_fb_tlast
);
    import fb_pkg::*;

    stream_word_t q_data [2];
    logic         q_last [2];
    logic [1:0]   wr_ptr;
    logic [1:0]   rd_ptr;
    logic         full;
    logic         empty;
    stream_word_t beat;

    // Keep the upper bits of red and blue, all of green
    function automatic rgb565_t to_rgb565(input pixel_t p);
        sub_pixel_t r;
        sub_pixel_t g;
        sub_pixel_t b;
        {r, g, b} = p;
        return {r[SUB_PIXEL_WIDTH-1 -: 5], g, b[SUB_PIXEL_WIDTH-1 -: 5]};
    endfunction

    always_comb
    begin
        for (int i = 0; i < PIXELS_PER_BEAT; i++)
            beat[i*$bits(rgb565_t) +: $bits(rgb565_t)] = to_rgb565(pair_data[i]);
    end

    // Pointer MSB tells full from empty
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[0] == rd_ptr[0]) && (wr_ptr[1] != rd_ptr[1]);

    assign pair_ready  = !full;
    assign m_fb_tvalid = !empty;
    assign m_fb_tdata  = q_data[rd_ptr[0]];
    assign m_fb_tlast  = q_last[rd_ptr[0]];

    always_ff @(posedge aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (pair_valid && pair_ready)
                wr_ptr <= wr_ptr + 1'b1;
            if (m_fb_tvalid && m_fb_tready)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (pair_valid && pair_ready)
        begin
            q_data[wr_ptr[0]] <= beat;
            q_last[wr_ptr[0]] <= pair_last;
        end
    end

endmodule

//--- design/raster_fb_top.sv
`timescale 1ns/1ps
// Top level joining the command decoder, colour buffer and stream output
module raster_fb_top
(
    input  logic                 aclk,
    input  logic                 arst_n,

    // Command stream
    input  logic                 s_cmd_tvalid,
    output logic                 s_cmd_tready,
    input  fb_pkg::cmd_word_t    s_cmd_tdata,

    // Framebuffer stream, two RGB565 pixels per beat
    output logic                 m_fb_tvalid,
    input  logic                 m_fb_tready,
    output fb_pkg::stream_word_t m_fb_tdata,
    output logic                 m_fb_tlast
);
    import fb_pkg::*;

    logic                            req_valid;
    logic                            req_ready;
    buf_req_t                        req_kind;
    screen_x_t                       req_x;
    screen_y_t                       req_y;
    pixel_t                          req_color;
    logic                            scissor_enable;
    screen_x_t                       scissor_start_x;
    screen_y_t                       scissor_start_y;
    screen_x_t                       scissor_end_x;
    screen_y_t                       scissor_end_y;
    channel_mask_t                   write_mask;
    logic                            pair_valid;
    logic                            pair_ready;
    pixel_t [PIXELS_PER_BEAT-1:0]    pair_data;
    logic                            pair_last;

    cmd_decoder cmd_decoder_i
    (
        .aclk            (aclk),
        .arst_n          (arst_n),
        .s_cmd_tvalid    (s_cmd_tvalid),
        .s_cmd_tready    (s_cmd_tready),
        .s_cmd_tdata     (s_cmd_tdata),
        .req_valid       (req_valid),
        .req_ready       (req_ready),
        .req_kind        (req_kind),
        .req_x           (req_x),
        .req_y           (req_y),
        .req_color       (req_color),
        .scissor_enable  (scissor_enable),
        .scissor_start_x (scissor_start_x),
        .scissor_start_y (scissor_start_y),
        .scissor_end_x   (scissor_end_x),
        .scissor_end_y   (scissor_end_y),
        .write_mask      (write_mask)
    );

    color_buffer color_buffer_i
    (
        .aclk            (aclk),
        .arst_n          (arst_n),
        .req_valid       (req_valid),
        .req_ready       (req_ready),
        .req_kind        (req_kind),
        .req_x           (req_x),
        .req_y           (req_y),
        .req_color       (req_color),
        .scissor_enable  (scissor_enable),
        .scissor_start_x (scissor_start_x),
        .scissor_start_y (scissor_start_y),
        .scissor_end_x   (scissor_end_x),
        .scissor_end_y   (scissor_end_y),
        .write_mask      (write_mask),
        .pair_valid      (pair_valid),
        .pair_ready      (pair_ready),
        .pair_data       (pair_data),
        .pair_last       (pair_last)
    );

    fb_stream_out fb_stream_out_i
    (
        .aclk            (aclk),
        .arst_n          (arst_n),
        .pair_valid      (pair_valid),
        .pair_ready      (pair_ready),
        .pair_data       (pair_data),
        .pair_last       (pair_last),
        .m_fb_tvalid     (m_fb_tvalid),
        .m_fb_tready     (m_fb_tready),
        .m_fb_tdata      (m_fb_tdata),
        .m_fb_tlast      (m_fb_tlast)
    );

endmodule

//--- dv/tb_raster_fb_model.svh
// Reference frame model, command encoders, RGB565 conversion, expected beat functions and LFSR
`ifndef TB_RASTER_FB_MODEL_SVH
`define TB_RASTER_FB_MODEL_SVH

// Model state starts at the decoder's reset values
pixel_t        model_frame  [FB_WORDS];
pixel_t        commit_frame [FB_WORDS];
pixel_t        model_clear = '0;
logic          model_sc_en = 1'b0;
screen_x_t     model_sc_x0 = '0;
screen_y_t     model_sc_y0 = '0;
screen_x_t     model_sc_x1 = screen_x_t'(FB_WIDTH - 1);
screen_y_t     model_sc_y1 = screen_y_t'(FB_HEIGHT - 1);
channel_mask_t model_mask  = '1;
logic [31:0]   lfsr_state  = 32'h629016c9;

// Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
        r = {r[30:0], lfsr_state[0]};
        lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
    end
    return r;
endfunction

// Command words
function automatic cmd_word_t enc_clear_color(input pixel_t c);
    return {OP_CLEAR_COLOR, 10'b0, c};
endfunction

function automatic cmd_word_t enc_scissor_start(input screen_x_t x, input screen_y_t y,
                                                input logic en);
    return {OP_SCISSOR_START, x, y, 20'b0, en};
endfunction

function automatic cmd_word_t enc_scissor_end(input screen_x_t x, input screen_y_t y);
    return {OP_SCISSOR_END, x, y, 21'b0};
endfunction

function automatic cmd_word_t enc_mask(input channel_mask_t m);
    return {OP_MASK, 25'b0, m};
endfunction

function automatic cmd_word_t enc_pixel(input screen_x_t x, input screen_y_t y, input pixel_t c);
    return {OP_PIXEL, x, y, 3'b0, c};
endfunction

function automatic cmd_word_t enc_op(input cmd_op_t op);
    return {op, 28'b0};
endfunction

// Scissor test and masked write into the model frame
function automatic void model_write(input screen_x_t x, input screen_y_t y, input pixel_t c);
    fb_addr_t a;
    a = {y, x};
    if (!model_sc_en || (x >= model_sc_x0 && x <= model_sc_x1
                      && y >= model_sc_y0 && y <= model_sc_y1))
    begin
        for (int ch = 0; ch < 3; ch++)
        begin
            if (model_mask[ch])
                model_frame[a][ch*SUB_PIXEL_WIDTH +: SUB_PIXEL_WIDTH] =
                    c[ch*SUB_PIXEL_WIDTH +: SUB_PIXEL_WIDTH];
        end
    end
endfunction

function automatic void model_memset();
    for (int i = 0; i < FB_WORDS; i++)
        model_write(screen_x_t'(i % FB_WIDTH), screen_y_t'(i / FB_WIDTH), model_clear);
endfunction

// Upper five red bits, six green bits, upper five blue bits
function automatic rgb565_t model_rgb565(input pixel_t p);
    return {p[17:13], p[11:6], p[5:1]};
endfunction

function automatic stream_word_t expected_beat(input int idx);
    return {model_rgb565(commit_frame[2*idx+1]), model_rgb565(commit_frame[2*idx])};
endfunction

function automatic logic expected_last(input int idx);
    return (idx == BEATS_PER_FRAME - 1);
endfunction

`endif

//--- dv/tb_raster_fb.sv
`timescale 1ns/1ps
// Testbench for the framebuffer top with clock, reset, command stimulus, beat checker and watchdog
module tb_raster_fb;
    import fb_pkg::*;

    localparam int CLK_PERIOD      = 20;
    localparam int DRIVE_DELAY     = 2;
    localparam int NUM_COMMITS     = 6;
    localparam int NUM_MEMSETS     = 3;
    localparam int WATCHDOG_CYCLES = NUM_COMMITS * 300 + NUM_MEMSETS * 200;

    logic         aclk;
    logic         arst_n;
    logic         s_cmd_tvalid;
    logic         s_cmd_tready;
    cmd_word_t    s_cmd_tdata;
    logic         m_fb_tvalid;
    logic         m_fb_tready;
    stream_word_t m_fb_tdata;
    logic         m_fb_tlast;

    logic         gaps_on = 1'b0;
    int           commits_sent = 0;
    int           commits_seen = 0;
    int           beat_count = 0;
    string        commit_name = "none";
    screen_x_t    late_x [4];
    screen_y_t    late_y [4];
    pixel_t       late_c [4];

    `include "tb_raster_fb_model.svh"

    raster_fb_top raster_fb_top_i
    (
        .aclk         (aclk),
        .arst_n       (arst_n),
        .s_cmd_tvalid (s_cmd_tvalid),
        .s_cmd_tready (s_cmd_tready),
        .s_cmd_tdata  (s_cmd_tdata),
        .m_fb_tvalid  (m_fb_tvalid),
        .m_fb_tready  (m_fb_tready),
        .m_fb_tdata   (m_fb_tdata),
        .m_fb_tlast   (m_fb_tlast)
    );

    initial
    begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic compare_word(input string name, input stream_word_t expected,
                                input stream_word_t actual);
        if (actual !== expected)
        begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic compare_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
            abort_run();
        end
    endtask

    // Called 2 ns after a rising edge and returns at the same point once the word is taken
    task automatic send_cmd(input cmd_word_t word);
        s_cmd_tdata  = word;
        s_cmd_tvalid = 1'b1;
        @(negedge aclk);
        while (!s_cmd_tready)
            @(negedge aclk);
        @(posedge aclk);
        #DRIVE_DELAY;
        s_cmd_tvalid = 1'b0;
    endtask

    task automatic set_clear(input pixel_t c);
        send_cmd(enc_clear_color(c));
        model_clear = c;
    endtask

    task automatic set_mask(input channel_mask_t m);
        send_cmd(enc_mask(m));
        model_mask = m;
    endtask

    task automatic set_scissor(input screen_x_t x0, input screen_y_t y0,
                               input screen_x_t x1, input screen_y_t y1, input logic en);
        send_cmd(enc_scissor_end(x1, y1));
        send_cmd(enc_scissor_start(x0, y0, en));
        model_sc_x0 = x0;
        model_sc_y0 = y0;
        model_sc_x1 = x1;
        model_sc_y1 = y1;
        model_sc_en = en;
    endtask

    task automatic write_pixel(input screen_x_t x, input screen_y_t y, input pixel_t c);
        send_cmd(enc_pixel(x, y, c));
        model_write(x, y, c);
    endtask

    task automatic write_random_pixels(input int count);
        screen_x_t x;
        screen_y_t y;
        pixel_t    c;
        for (int i = 0; i < count; i++)
        begin
            x = screen_x_t'(rand_bits(4));
            y = screen_y_t'(rand_bits(3));
            c = pixel_t'(rand_bits(18));
            write_pixel(x, y, c);
        end
    endtask

    task automatic run_memset();
        send_cmd(enc_op(OP_MEMSET));
        model_memset();
    endtask

    // Snapshot taken before the word goes out so later writes reach only the live model
    task automatic run_commit(input string name);
        commit_frame = model_frame;
        commit_name  = name;
        commits_sent++;
        send_cmd(enc_op(OP_COMMIT));
    endtask

    task automatic wait_commits();
        while (commits_seen != commits_sent)
            @(posedge aclk);
        @(posedge aclk);
        #DRIVE_DELAY;
    endtask

    // Random gaps in m_fb_tready while gaps_on is set
    initial
    begin
        m_fb_tready = 1'b1;
        forever
        begin
            @(posedge aclk);
            #DRIVE_DELAY;
            if (gaps_on)
                m_fb_tready = (rand_bits(1) == 32'd1);
            else
                m_fb_tready = 1'b1;
        end
    end

    // Checker samples mid cycle and the transfer happens on the next rising edge
    initial
    begin
        forever
        begin
            @(negedge aclk);
            if (arst_n && m_fb_tvalid && m_fb_tready)
            begin
                if (commits_seen == commits_sent)
                begin
                    $display("A beat appeared on the stream with no commit pending");
                    abort_run();
                end
                else
                begin
                    compare_word($sformatf("%s beat %0d data", commit_name, beat_count),
                                 expected_beat(beat_count), m_fb_tdata);
                    compare_flag($sformatf("%s beat %0d tlast", commit_name, beat_count),
                                 expected_last(beat_count), m_fb_tlast);
                    if (beat_count == BEATS_PER_FRAME - 1)
                    begin
                        beat_count = 0;
                        commits_seen++;
                    end
                    else
                    begin
                        beat_count++;
                    end
                end
            end
        end
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge aclk);
        $display("Watchdog expired after %0d cycles, the DUT stopped making progress",
                 WATCHDOG_CYCLES);
        abort_run();
    end

    initial
    begin
        screen_x_t sx0;
        screen_x_t sx1;
        screen_x_t tx;
        screen_y_t sy0;
        screen_y_t sy1;
        screen_y_t ty;

        arst_n       = 1'b0;
        s_cmd_tvalid = 1'b0;
        s_cmd_tdata  = '0;
        repeat (3) @(posedge aclk);
        #DRIVE_DELAY;
        arst_n = 1'b1;

        // After reset
        @(negedge aclk);
        compare_flag("reset m_fb_tvalid", 1'b0, m_fb_tvalid);
        compare_flag("reset s_cmd_tready", 1'b1, s_cmd_tready);
        @(posedge aclk);
        #DRIVE_DELAY;

        // Clear and commit
        set_clear(pixel_t'(rand_bits(18)));
        set_mask(3'b111);
        run_memset();
        run_commit("clear_commit");
        wait_commits();

        // Pixel writes
        write_random_pixels(20);
        run_commit("pixel_commit");
        wait_commits();

        // Scissor rectangle with sorted corners so it is never empty
        sx0 = screen_x_t'(rand_bits(4));
        sx1 = screen_x_t'(rand_bits(4));
        sy0 = screen_y_t'(rand_bits(3));
        sy1 = screen_y_t'(rand_bits(3));
        if (sx0 > sx1)
        begin
            tx  = sx0;
            sx0 = sx1;
            sx1 = tx;
        end
        if (sy0 > sy1)
        begin
            ty  = sy0;
            sy0 = sy1;
            sy1 = ty;
        end
        set_scissor(sx0, sy0, sx1, sy1, 1'b1);
        set_clear(pixel_t'(rand_bits(18)));
        run_memset();
        write_random_pixels(16);
        // One pixel on the inside corner and one just past the opposite corner
        write_pixel(sx0, sy0, pixel_t'(rand_bits(18)));
        write_pixel(screen_x_t'(sx1 + 1'b1), screen_y_t'(sy1 + 1'b1), pixel_t'(rand_bits(18)));
        run_commit("scissor_commit");
        wait_commits();
        set_scissor('0, '0, screen_x_t'(FB_WIDTH - 1), screen_y_t'(FB_HEIGHT - 1), 1'b0);

        // Channel masks
        for (int r = 0; r < 3; r++)
        begin
            set_mask(channel_mask_t'(rand_bits(3)));
            write_random_pixels(4);
        end
        set_mask(channel_mask_t'(rand_bits(3)));
        set_clear(pixel_t'(rand_bits(18)));
        run_memset();
        set_mask(3'b111);
        run_commit("mask_commit");
        wait_commits();

        // Back-pressure with writes queued behind the commit
        for (int i = 0; i < 4; i++)
        begin
            late_x[i] = screen_x_t'(rand_bits(4));
            late_y[i] = screen_y_t'(rand_bits(3));
            late_c[i] = pixel_t'(rand_bits(18));
        end
        @(negedge aclk);
        gaps_on = 1'b1;
        @(posedge aclk);
        #DRIVE_DELAY;
        run_commit("backpressure_commit");
        for (int i = 0; i < 4; i++)
            write_pixel(late_x[i], late_y[i], late_c[i]);
        wait_commits();
        @(negedge aclk);
        gaps_on = 1'b0;
        @(posedge aclk);
        #DRIVE_DELAY;
        run_commit("followup_commit");
        wait_commits();

        // Both interfaces idle after the last frame
        repeat (20) @(posedge aclk);
        @(negedge aclk);
        compare_flag("final m_fb_tvalid", 1'b0, m_fb_tvalid);
        compare_flag("final s_cmd_tready", 1'b1, s_cmd_tready);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- project.f
+incdir+dv
design/fb_pkg.sv
design/cmd_decoder.sv
design/color_buffer.sv
design/fb_stream_out.sv
design/raster_fb_top.sv
dv/tb_raster_fb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the framebuffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG_FILE=sim.log

verilator --binary --timing -sv -f project.f --top-module tb_raster_fb \
    -Mdir "$BUILD_DIR" -o sim_tb_raster_fb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_tb_raster_fb" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "ALL CHECKS PASSED" "$LOG_FILE"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
